// ==== build.f ====
rtl/sccb_pkg.sv
rtl/sccb_clk_gen.sv
rtl/sccb_master.sv
rtl/sccb_config_seq.sv
rtl/sccb_top.sv
sim/sccb_bus_monitor.sv
sim/tb_sccb_top.sv

// ==== Bender.yml ====
package:
  name: sccb_config

sources:
  - rtl/sccb_pkg.sv
  - rtl/sccb_clk_gen.sv
  - rtl/sccb_master.sv
  - rtl/sccb_config_seq.sv
  - rtl/sccb_top.sv
  - target: simulation
    files:
      - sim/sccb_bus_monitor.sv
      - sim/tb_sccb_top.sv

// ==== sim/tb_sccb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sccb_top;

	localparam int CLK_NS          = 40;
	localparam int HI_CYCLES       = 2 * sccb_pkg::QUARTER_DIV;
	localparam int SLOT_CYCLES     = 4 * sccb_pkg::QUARTER_DIV;
	// from the start in slot 0 quarter 2 to the stop in the last slot quarter 2
	localparam int SPAN_CYCLES     = (sccb_pkg::BIT_SLOTS - 1) * SLOT_CYCLES;
	localparam int RUN_LIMIT       = sccb_pkg::CFG_LEN * (sccb_pkg::FRAME_CYCLES + 10) + 50;
	localparam int WATCHDOG_CYCLES = 3 * sccb_pkg::CFG_LEN * sccb_pkg::FRAME_CYCLES + 1000;

	// one decoded frame without the ack bits
	typedef struct packed {
		sccb_pkg::dev_addr_t  dev_addr;
		logic                 rw;
		sccb_pkg::sccb_byte_t data;
	} frame_t;

	logic        clk = 1'b0;
	logic        reset;
	logic        cfg_start;
	logic        busy;
	logic        done;
	logic        scl;
	logic        sda;
	logic        in_frame;
	logic        start_seen;
	logic        stop_seen;
	logic [17:0] frame_bits;
	logic [4:0]  frame_nbits;
	logic [9:0]  frame_len;
	logic        hi_done;
	logic [7:0]  hi_len;
	logic        slot_done;
	logic [7:0]  slot_len;
	logic        sda_moved;
	logic        busy_q = 1'b0;
	logic        done_q = 1'b0;

	int err_count    = 0;
	int test_base    = 0;
	int pass_tests   = 0;
	int fail_tests   = 0;
	int run_frames   = 0;
	int total_frames = 0;
	int total_starts = 0;
	int base_frames  = 0;
	int base_starts  = 0;

	always #(CLK_NS / 2) clk = ~clk;

	sccb_top u_dut (
		.clk       (clk),
		.reset     (reset),
		.cfg_start (cfg_start),
		.busy      (busy),
		.done      (done),
		.scl       (scl),
		.sda       (sda)
	);

	sccb_bus_monitor u_mon (
		.clk         (clk),
		.reset       (reset),
		.scl         (scl),
		.sda         (sda),
		.in_frame    (in_frame),
		.start_seen  (start_seen),
		.stop_seen   (stop_seen),
		.frame_bits  (frame_bits),
		.frame_nbits (frame_nbits),
		.frame_len   (frame_len),
		.hi_done     (hi_done),
		.hi_len      (hi_len),
		.slot_done   (slot_done),
		.slot_len    (slot_len),
		.sda_moved   (sda_moved)
	);

	// frame k of a run carries table entry k as a write
	function automatic frame_t expected_frame(input int k);
		frame_t f;
		f.dev_addr = sccb_pkg::CFG_TABLE[k].dev_addr;
		f.rw       = 1'b0;
		f.data     = sccb_pkg::CFG_TABLE[k].data;
		return f;
	endfunction

	task automatic compare_value(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			err_count++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("Failure at %0t ns: %s", $time, what);
			err_count++;
		end
	endtask

	task automatic close_test(input string name);
		int errs;
		errs = err_count - test_base;
		if (errs == 0) begin
			pass_tests++;
			$display("PASS  %s", name);
		end else begin
			fail_tests++;
			$display("FAIL  %s (%0d errors)", name, errs);
		end
		test_base = err_count;
	endtask

	task automatic pulse_cfg_start();
		@(negedge clk);
		cfg_start = 1'b1;
		@(negedge clk);
		cfg_start = 1'b0;
	endtask

	// pulse while idle and expect busy one cycle later
	task automatic start_run();
		base_frames = total_frames;
		base_starts = total_starts;
		check_true(!busy, "busy already high before cfg_start");
		pulse_cfg_start();
		compare_value("busy", busy, 1);
	endtask

	task automatic finish_run();
		int n;
		n = 0;
		while (!done && n < RUN_LIMIT) begin
			@(negedge clk);
			n++;
		end
		check_true(done, "timed out waiting for done");
		@(negedge clk);
		compare_value("frames in run", total_frames - base_frames, sccb_pkg::CFG_LEN);
		compare_value("starts in run", total_starts - base_starts, sccb_pkg::CFG_LEN);
	endtask

	// decoded frames and bus timing against the reference
	always @(negedge clk) begin
		frame_t got;
		frame_t exp;
		if (!reset) begin
			if (busy && !busy_q) begin
				run_frames = 0;
			end
			if (start_seen) begin
				total_starts++;
			end
			if (stop_seen) begin
				compare_value("frame_nbits", frame_nbits, 18);
				compare_value("frame_len", frame_len, SPAN_CYCLES);
				if (run_frames < sccb_pkg::CFG_LEN) begin
					got = {frame_bits[17:10], frame_bits[8:1]};
					exp = expected_frame(run_frames);
					compare_value("dev_addr", got.dev_addr, exp.dev_addr);
					compare_value("rw", got.rw, exp.rw);
					compare_value("data", got.data, exp.data);
				end else begin
					check_true(1'b0, "more frames in one run than table entries");
				end
				run_frames++;
				total_frames++;
			end
			if (hi_done) begin
				compare_value("scl high cycles", hi_len, HI_CYCLES);
			end
			if (slot_done) begin
				compare_value("bit slot cycles", slot_len, SLOT_CYCLES);
			end
			check_true(!sda_moved, "sda changed while scl was low after quarter 0");
			if (in_frame) begin
				check_true(busy, "frame on the bus while busy is low");
			end
			if (done) begin
				check_true(!done_q, "done stayed high for more than one cycle");
				check_true(!busy && busy_q, "busy did not fall together with done");
				check_true(!in_frame, "done came before the last stop condition");
				compare_value("frames before done", run_frames, sccb_pkg::CFG_LEN);
			end
			if (busy_q && !busy) begin
				check_true(done, "busy fell without a done pulse");
			end
		end
		busy_q = busy;
		done_q = done;
	end

	initial begin
		int n;
		reset     = 1'b1;
		cfg_start = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// bus must stay released with no cfg_start
		repeat (50) begin
			@(negedge clk);
			compare_value("scl", scl, 1);
			compare_value("sda", sda, 1);
			compare_value("busy", busy, 0);
			compare_value("done", done, 0);
		end
		compare_value("start conditions", total_starts, 0);
		close_test("idle after reset");

		start_run();
		finish_run();
		close_test("first run, frame contents and timing");

		// second pulse lands inside the first frame
		start_run();
		n = 0;
		while (!start_seen && n < RUN_LIMIT) begin
			@(negedge clk);
			n++;
		end
		check_true(start_seen, "no start condition after cfg_start");
		pulse_cfg_start();
		compare_value("busy", busy, 1);
		finish_run();
		// room for a whole extra frame if the ignored pulse had started a run
		repeat (sccb_pkg::FRAME_CYCLES + 2 * SLOT_CYCLES) @(negedge clk);
		compare_value("busy", busy, 0);
		compare_value("frames after done", total_frames - base_frames, sccb_pkg::CFG_LEN);
		close_test("cfg_start while busy is ignored");

		repeat (5) @(negedge clk);
		start_run();
		finish_run();
		close_test("new run after done");

		$display("summary: passed %0d, failed %0d, check errors %0d",
			pass_tests, fail_tests, err_count);
		if (fail_tests == 0 && err_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// three full runs plus idle stretches
	initial begin
		#(WATCHDOG_CYCLES * CLK_NS);
		$display("watchdog expired before all tests finished");
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/sccb_bus_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module sccb_bus_monitor (
	input  logic        clk,
	input  logic        reset,
	input  logic        scl,
	input  logic        sda,
	output logic        in_frame,
	output logic        start_seen,
	output logic        stop_seen,
	output logic [17:0] frame_bits,
	output logic [4:0]  frame_nbits,
	output logic [9:0]  frame_len,
	output logic        hi_done,
	output logic [7:0]  hi_len,
	output logic        slot_done,
	output logic [7:0]  slot_len,
	output logic        sda_moved
);

	logic       scl_q;
	logic       sda_q;
	logic       scl_rise;
	logic       scl_fall;
	logic       hi_track;
	logic       fell_once;
	logic [7:0] hi_cnt;
	logic [7:0] fall_cnt;

	assign scl_rise = !scl_q && scl;
	assign scl_fall = scl_q && !scl;

	always_ff @(posedge clk) begin
		if (reset) begin
			scl_q       <= 1'b1;
			sda_q       <= 1'b1;
			in_frame    <= 1'b0;
			start_seen  <= 1'b0;
			stop_seen   <= 1'b0;
			frame_bits  <= '0;
			frame_nbits <= '0;
			frame_len   <= '0;
			hi_done     <= 1'b0;
			hi_len      <= '0;
			slot_done   <= 1'b0;
			slot_len    <= '0;
			sda_moved   <= 1'b0;
			hi_track    <= 1'b0;
			fell_once   <= 1'b0;
			hi_cnt      <= '0;
			fall_cnt    <= '0;
		end else begin
			scl_q      <= scl;
			sda_q      <= sda;
			start_seen <= 1'b0;
			stop_seen  <= 1'b0;
			hi_done    <= 1'b0;
			slot_done  <= 1'b0;
			hi_cnt     <= hi_cnt + 8'd1;
			fall_cnt   <= fall_cnt + 8'd1;

			// sda may move with scl high (start, stop) or together with the scl fall
			sda_moved <= in_frame && (sda != sda_q) && !scl_q;

			if (scl_q && scl && sda_q && !sda) begin
				start_seen  <= 1'b1;
				in_frame    <= 1'b1;
				frame_bits  <= '0;
				frame_nbits <= '0;
				frame_len   <= 10'd1;
				hi_track    <= 1'b0;
				fell_once   <= 1'b0;
			end else if (scl_q && scl && !sda_q && sda) begin
				stop_seen <= 1'b1;
				in_frame  <= 1'b0;
			end else if (in_frame) begin
				frame_len <= frame_len + 10'd1;
			end

			if (in_frame && scl_rise) begin
				hi_cnt   <= 8'd1;
				hi_track <= 1'b1;
			end

			// bit taken at the end of its high phase, the stop rise never gets here
			if (in_frame && scl_fall) begin
				fall_cnt  <= 8'd1;
				fell_once <= 1'b1;
				slot_done <= fell_once;
				slot_len  <= fall_cnt;
				if (hi_track) begin
					hi_track    <= 1'b0;
					hi_done     <= 1'b1;
					hi_len      <= hi_cnt;
					frame_bits  <= {frame_bits[16:0], sda_q};
					frame_nbits <= frame_nbits + 5'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sccb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sccb_top (
	input  logic clk,
	input  logic reset,
	input  logic cfg_start,
	output logic busy,
	output logic done,
	output logic scl,
	output logic sda
);

	sccb_pkg::sccb_write_t wr;
	logic                  wr_start;
	logic                  ready;
	logic                  run;
	logic                  qtick;

	// walks the table, one write per frame
	sccb_config_seq u_seq (
		.clk       (clk),
		.reset     (reset),
		.cfg_start (cfg_start),
		.ready     (ready),
		.wr        (wr),
		.wr_start  (wr_start),
		.busy      (busy),
		.done      (done)
	);

	// bit level frame engine
	sccb_master u_master (
		.clk      (clk),
		.reset    (reset),
		.wr       (wr),
		.wr_start (wr_start),
		.qtick    (qtick),
		.run      (run),
		.ready    (ready),
		.scl      (scl),
		.sda      (sda)
	);

	// quarter bit enables in the clk domain
	sccb_clk_gen u_clk_gen (
		.clk   (clk),
		.reset (reset),
		.run   (run),
		.qtick (qtick)
	);

endmodule

`default_nettype wire

// ==== rtl/sccb_config_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module sccb_config_seq (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cfg_start,
	input  logic                  ready,
	output sccb_pkg::sccb_write_t wr,
	output logic                  wr_start,
	output logic                  busy,
	output logic                  done
);

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT_LOW,
		WAIT_HIGH
	} state_t;

	state_t             state;
	sccb_pkg::cfg_idx_t idx;
	logic               last_entry;

	// table entry for the current index
	assign wr = sccb_pkg::CFG_TABLE[idx];

	assign last_entry = (idx == sccb_pkg::cfg_idx_t'(sccb_pkg::CFG_LEN - 1));

	// master takes it in this same cycle since ready is high
	assign wr_start = (state == ISSUE) && ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			idx   <= '0;
			busy  <= 1'b0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;

			case (state)
				IDLE: begin
					// a new run only once the last one has finished
					if (cfg_start && !busy) begin
						state <= ISSUE;
						idx   <= '0;
						busy  <= 1'b1;
					end
				end
				ISSUE: begin
					if (ready) begin
						state <= WAIT_LOW;
					end
				end
				WAIT_LOW: begin
					// master drops ready one clk after accepting
					if (!ready) begin
						state <= WAIT_HIGH;
					end
				end
				WAIT_HIGH: begin
					if (ready) begin
						if (last_entry) begin
							state <= IDLE;
							busy  <= 1'b0;
							done  <= 1'b1;
						end else begin
							state <= ISSUE;
							idx   <= idx + 1'b1;
						end
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sccb_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module sccb_master (
	input  logic                  clk,
	input  logic                  reset,
	input  sccb_pkg::sccb_write_t wr,
	input  logic                  wr_start,
	input  logic                  qtick,
	output logic                  run,
	output logic                  ready,
	output logic                  scl,
	output logic                  sda
);

	typedef enum logic [2:0] {
		IDLE,
		START,
		ADDR,
		RW,
		ACK1,
		DATA,
		ACK2,
		STOP
	} state_t;

	state_t                state;
	state_t                state_nxt;
	logic [2:0]            bit_cnt;
	logic [2:0]            bit_nxt;
	logic [1:0]            qtr;
	logic [1:0]            qtr_nxt;
	logic                  scl_nxt;
	logic                  sda_nxt;
	logic                  accept;
	sccb_pkg::sccb_write_t wr_q;

	// new frame only taken while idle and ready
	assign accept = (state == IDLE) && ready && wr_start;

	// position after the next quarter tick
	always_comb begin
		state_nxt = state;
		bit_nxt   = bit_cnt;
		qtr_nxt   = qtr + 2'd1;

		// slot boundary, move on to the next slot
		if (qtr == 2'd3) begin
			case (state)
				START: begin
					state_nxt = ADDR;
					bit_nxt   = 3'd6;
				end
				ADDR: begin
					if (bit_cnt == 3'd0) begin
						state_nxt = RW;
					end else begin
						bit_nxt = bit_cnt - 3'd1;
					end
				end
				RW: begin
					state_nxt = ACK1;
				end
				ACK1: begin
					state_nxt = DATA;
					bit_nxt   = 3'd7;
				end
				DATA: begin
					if (bit_cnt == 3'd0) begin
						state_nxt = ACK2;
					end else begin
						bit_nxt = bit_cnt - 3'd1;
					end
				end
				ACK2: begin
					state_nxt = STOP;
				end
				STOP: begin
					state_nxt = IDLE;
				end
				default: begin
					state_nxt = IDLE;
				end
			endcase
		end
	end

	// line levels for the quarter being entered
	always_comb begin
		scl_nxt = 1'b1;
		sda_nxt = 1'b1;

		case (state_nxt)
			START: begin
				// scl stays high, sda falls halfway through
				scl_nxt = 1'b1;
				sda_nxt = (qtr_nxt < 2'd2);
			end
			ADDR: begin
				scl_nxt = qtr_nxt[1];
				sda_nxt = wr_q.dev_addr[bit_nxt];
			end
			RW: begin
				// write only
				scl_nxt = qtr_nxt[1];
				sda_nxt = 1'b0;
			end
			ACK1, ACK2: begin
				// ninth bit is don't care, line released
				scl_nxt = qtr_nxt[1];
				sda_nxt = 1'b1;
			end
			DATA: begin
				scl_nxt = qtr_nxt[1];
				sda_nxt = wr_q.data[bit_nxt];
			end
			STOP: begin
				// scl up at quarter 1, then sda up while scl high
				scl_nxt = (qtr_nxt != 2'd0);
				sda_nxt = qtr_nxt[1];
			end
			default: begin
				scl_nxt = 1'b1;
				sda_nxt = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= IDLE;
			bit_cnt <= 3'd0;
			qtr     <= 2'd0;
			run     <= 1'b0;
			ready   <= 1'b1;
			scl     <= 1'b1;
			sda     <= 1'b1;
		end else if (state == IDLE) begin
			if (accept) begin
				// slot 0 quarter 0 starts here, lines are already idle high
				state   <= START;
				bit_cnt <= 3'd0;
				qtr     <= 2'd0;
				run     <= 1'b1;
				ready   <= 1'b0;
			end else begin
				// one clk of settling after the stop slot
				ready <= 1'b1;
			end
			scl <= 1'b1;
			sda <= 1'b1;
		end else if (qtick) begin
			state   <= state_nxt;
			bit_cnt <= bit_nxt;
			qtr     <= qtr_nxt;
			scl     <= scl_nxt;
			sda     <= sda_nxt;
			run     <= (state_nxt != IDLE);
		end
	end

	// frame contents held for the whole frame
	always_ff @(posedge clk) begin
		if (accept) begin
			wr_q <= wr;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sccb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module sccb_clk_gen (
	input  logic clk,
	input  logic reset,
	input  logic run,
	output logic qtick
);

	sccb_pkg::div_cnt_t cnt;
	logic               cnt_wrap;

	// last clk of a quarter
	assign cnt_wrap = (cnt == sccb_pkg::div_cnt_t'(sccb_pkg::QUARTER_DIV - 1));

	// one pulse per quarter, only while a frame is on the bus
	assign qtick = run && cnt_wrap;

	// held at zero between frames so every frame starts on the same phase
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
		end else if (!run) begin
			cnt <= '0;
		end else if (cnt_wrap) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sccb_pkg.sv ====
`default_nettype none

package sccb_pkg;

	// bus device address, sent msb first
	typedef logic [6:0] dev_addr_t;

	// one register data byte
	typedef logic [7:0] sccb_byte_t;

	// one write frame: address phase then data phase
	typedef struct packed {
		dev_addr_t  dev_addr;
		sccb_byte_t data;
	} sccb_write_t;

	// clk cycles per quarter of a bus bit
	localparam int QUARTER_DIV = 4;

	// start, 7 addr, rw, ack, 8 data, ack, stop
	localparam int BIT_SLOTS = 20;

	// clk cycles from accept to the last quarter tick
	localparam int FRAME_CYCLES = BIT_SLOTS * 4 * QUARTER_DIV;

	// divider counter, one count per clk inside a quarter
	typedef logic [$clog2(QUARTER_DIV)-1:0] div_cnt_t;

	// number of entries in the configuration table
	localparam int CFG_LEN = 4;

	// table index
	typedef logic [1:0] cfg_idx_t;

	// camera bring-up writes, issued in order
	localparam sccb_write_t CFG_TABLE [CFG_LEN] = '{
		'{dev_addr: 7'h21, data: 8'h80},
		'{dev_addr: 7'h21, data: 8'h04},
		'{dev_addr: 7'h3c, data: 8'h1e},
		'{dev_addr: 7'h3c, data: 8'hc3}
	};

endpackage

`default_nettype wire
